//--- source/sync_pkg.sv
package sync_pkg;

    localparam int SAMPLE_DW = 16;

    typedef struct packed {
        logic [SAMPLE_DW-1:0] re;
        logic [SAMPLE_DW-1:0] im;
    } iq_sample_t;

    typedef struct packed {
        iq_sample_t data;
        logic       valid;
    } iq_stream_t;

    // decimation filter
    localparam int CIC_RATE       = 2;
    localparam int CIC_ORDER      = 2;
    localparam int CIC_GAIN_SHIFT = 2;  // gain (R*M)^N = 4
    localparam int CIC_ACC_DW     = SAMPLE_DW + CIC_ORDER * $clog2(CIC_RATE);
    localparam int CIC_CNT_W      = $clog2(CIC_RATE);

    // sign patterns, msb is the oldest sample, 1 = +1 and 0 = -1
    localparam int PSS_LEN = 16;
    localparam logic [PSS_LEN-1:0] PSS_SEQ_0 = 16'hE4B1;
    localparam logic [PSS_LEN-1:0] PSS_SEQ_1 = 16'h3A69;
    localparam logic [PSS_LEN-1:0] PSS_SEQ_2 = 16'h8D2E;

    typedef logic [1:0] nid2_t;

    localparam int DELAY_LEN = 1;  // matches correlator latency

    // framing
    localparam int CP_LEN         = 4;
    localparam int SYM_LEN        = 8;
    localparam int SYMS_PER_BURST = 2;
    localparam int FRM_CNT_W      = $clog2(SYM_LEN);

    typedef logic [0:0] sym_idx_t;

    typedef struct packed {
        iq_sample_t data;
        logic       valid;
        logic       first;
        logic       last;
        sym_idx_t   index;
    } framed_stream_t;

endpackage

//--- source/cic_decimator.sv
`timescale 1ns/10ps

module cic_decimator import sync_pkg::*; (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  logic [SAMPLE_DW-1:0] in_data_i,
    input  logic                 in_valid_i,
    output logic [SAMPLE_DW-1:0] out_data_o,
    output logic                 out_valid_o
);

    logic signed [CIC_ACC_DW-1:0] in_ext;
    logic signed [CIC_ACC_DW-1:0] integ_q   [CIC_ORDER];
    logic signed [CIC_ACC_DW-1:0] integ_d   [CIC_ORDER];
    logic signed [CIC_ACC_DW-1:0] comb_dly  [CIC_ORDER];  // one low-rate sample per stage
    logic signed [CIC_ACC_DW-1:0] comb_d    [CIC_ORDER+1];
    logic signed [CIC_ACC_DW-1:0] comb_shift;
    logic        [CIC_CNT_W-1:0]  rate_cnt;
    logic                         take;

    assign in_ext = {{(CIC_ACC_DW-SAMPLE_DW){in_data_i[SAMPLE_DW-1]}}, in_data_i};
    assign take   = in_valid_i && (rate_cnt == '0);

    // integrators see the current input, so the combs run on the fresh sum
    always_comb begin
        integ_d[0] = integ_q[0] + in_ext;
        for (int i = 1; i < CIC_ORDER; i++) begin
            integ_d[i] = integ_q[i] + integ_d[i-1];
        end
        comb_d[0] = integ_d[CIC_ORDER-1];
        for (int i = 0; i < CIC_ORDER; i++) begin
            comb_d[i+1] = comb_d[i] - comb_dly[i];
        end
    end

    assign comb_shift = comb_d[CIC_ORDER] >>> CIC_GAIN_SHIFT;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int i = 0; i < CIC_ORDER; i++) begin
                integ_q[i]  <= '0;
                comb_dly[i] <= '0;
            end
            rate_cnt    <= '0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= take;
            if (in_valid_i) begin
                integ_q  <= integ_d;
                rate_cnt <= (rate_cnt == CIC_CNT_W'(CIC_RATE - 1)) ? '0 : rate_cnt + 1'b1;
            end
            if (take) begin
                for (int i = 0; i < CIC_ORDER; i++) begin
                    comb_dly[i] <= comb_d[i];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) out_data_o <= comb_shift[SAMPLE_DW-1:0];  // wraps on overflow
    end

endmodule

//--- source/pss_correlator.sv
`timescale 1ns/10ps

module pss_correlator import sync_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_ni,
    input  iq_stream_t dec_i,
    output logic       peak_valid_o,
    output nid2_t      peak_nid2_o
);

    logic [PSS_LEN-1:0] win_q;
    logic [PSS_LEN-1:0] win_next;
    logic [PSS_LEN-1:0] fill_q;     // marks how far the window is filled
    logic [PSS_LEN-1:0] fill_next;
    logic               sign_bit;
    logic [2:0]         hit;
    logic               match;
    nid2_t              hit_nid2;

    assign sign_bit  = ~dec_i.data.re[SAMPLE_DW-1];  // 1 for re >= 0
    assign win_next  = {win_q[PSS_LEN-2:0], sign_bit};
    assign fill_next = {fill_q[PSS_LEN-2:0], 1'b1};

    // exact match on the window including the incoming sample
    assign hit[0] = (win_next == PSS_SEQ_0);
    assign hit[1] = (win_next == PSS_SEQ_1);
    assign hit[2] = (win_next == PSS_SEQ_2);
    assign match  = fill_next[PSS_LEN-1] && (|hit);

    always_comb begin
        if (hit[0]) begin
            hit_nid2 = 2'd0;
        end else if (hit[1]) begin
            hit_nid2 = 2'd1;
        end else begin
            hit_nid2 = 2'd2;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            win_q        <= '0;
            fill_q       <= '0;
            peak_valid_o <= 1'b0;
            peak_nid2_o  <= '0;
        end else begin
            peak_valid_o <= 1'b0;
            if (dec_i.valid) begin
                win_q  <= win_next;
                fill_q <= fill_next;
                if (match) begin
                    peak_valid_o <= 1'b1;
                    peak_nid2_o  <= hit_nid2;  // held until the next detection
                end
            end
        end
    end

endmodule

//--- source/sample_delay.sv
`timescale 1ns/10ps

module sample_delay import sync_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_ni,
    input  iq_stream_t in_i,
    output iq_stream_t out_o
);

    iq_stream_t dly_q [DELAY_LEN];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int i = 0; i < DELAY_LEN; i++) begin
                dly_q[i] <= '0;
            end
        end else begin
            dly_q[0] <= in_i;
            for (int i = 1; i < DELAY_LEN; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    assign out_o = dly_q[DELAY_LEN-1];

endmodule

//--- source/symbol_framer.sv
`timescale 1ns/10ps

module symbol_framer import sync_pkg::*; (
    input  logic           clk_i,
    input  logic           reset_ni,
    input  iq_stream_t     stream_i,
    input  logic           peak_valid_i,
    output framed_stream_t sym_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREFIX,
        ST_BODY
    } frm_state_t;

    frm_state_t           state;
    logic [FRM_CNT_W-1:0] samp_cnt;
    sym_idx_t             sym_cnt;
    logic                 body_last;

    assign body_last = (samp_cnt == FRM_CNT_W'(SYM_LEN - 1));

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state    <= ST_IDLE;
            samp_cnt <= '0;
            sym_cnt  <= '0;
            sym_o    <= '0;
        end else begin
            sym_o.valid <= 1'b0;
            sym_o.first <= 1'b0;
            sym_o.last  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // sample arriving with the peak is the last pss sample, not counted
                    if (peak_valid_i) begin
                        state    <= ST_PREFIX;
                        samp_cnt <= '0;
                        sym_cnt  <= '0;
                    end
                end
                ST_PREFIX: begin
                    if (stream_i.valid) begin
                        if (samp_cnt == FRM_CNT_W'(CP_LEN - 1)) begin
                            state    <= ST_BODY;
                            samp_cnt <= '0;
                        end else begin
                            samp_cnt <= samp_cnt + 1'b1;
                        end
                    end
                end
                ST_BODY: begin
                    if (stream_i.valid) begin
                        sym_o.data  <= stream_i.data;
                        sym_o.valid <= 1'b1;
                        sym_o.first <= (samp_cnt == '0);
                        sym_o.last  <= body_last;
                        sym_o.index <= sym_cnt;
                        if (body_last) begin
                            samp_cnt <= '0;
                            if (sym_cnt == sym_idx_t'(SYMS_PER_BURST - 1)) begin
                                state <= ST_IDLE;
                            end else begin
                                sym_cnt <= sym_cnt + 1'b1;
                                state   <= ST_PREFIX;  // next cyclic prefix
                            end
                        end else begin
                            samp_cnt <= samp_cnt + 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- source/sync_top.sv
`timescale 1ns/10ps

module sync_top import sync_pkg::*; (
    input  logic           clk_i,
    input  logic           reset_ni,
    input  iq_stream_t     in_i,
    output iq_stream_t     dec_o,
    output logic           peak_valid_o,
    output nid2_t          peak_nid2_o,
    output framed_stream_t sym_o
);

    logic [SAMPLE_DW-1:0] dec_re;
    logic [SAMPLE_DW-1:0] dec_im;
    logic                 dec_valid;
    iq_stream_t           dec_stream;
    iq_stream_t           dly_stream;
    logic                 peak_valid;
    nid2_t                peak_nid2;

    cic_decimator u_cic_re (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_data_i   (in_i.data.re),
        .in_valid_i  (in_i.valid),
        .out_data_o  (dec_re),
        .out_valid_o (dec_valid)
    );

    // runs in lockstep with the real filter
    cic_decimator u_cic_im (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_data_i   (in_i.data.im),
        .in_valid_i  (in_i.valid),
        .out_data_o  (dec_im),
        .out_valid_o ()
    );

    assign dec_stream = '{data: '{re: dec_re, im: dec_im}, valid: dec_valid};

    pss_correlator u_pss (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .dec_i        (dec_stream),
        .peak_valid_o (peak_valid),
        .peak_nid2_o  (peak_nid2)
    );

    sample_delay u_delay (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .in_i     (dec_stream),
        .out_o    (dly_stream)
    );

    symbol_framer u_framer (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .stream_i     (dly_stream),
        .peak_valid_i (peak_valid),
        .sym_o        (sym_o)
    );

    assign dec_o        = dec_stream;  // debug taps
    assign peak_valid_o = peak_valid;
    assign peak_nid2_o  = peak_nid2;

endmodule

//--- verification/sync_tb.sv
`timescale 1ns/10ps

module sync_tb import sync_pkg::*; ();

    localparam int MAX_IDLE = 3;  // idle cycles between valid inputs, 0..MAX_IDLE
    localparam int BURST_SAMPLES = SYMS_PER_BURST * (CP_LEN + SYM_LEN);

    logic           clk_i;
    logic           reset_ni;
    iq_stream_t     in_i;
    iq_stream_t     dec_o;
    logic           peak_valid_o;
    nid2_t          peak_nid2_o;
    framed_stream_t sym_o;

    logic [31:0]    stim_q [$];   // {re, im} per input sample
    int             nid_q [$];    // expected n_id_2 per PSS, in file order
    iq_sample_t     dec_q [$];
    framed_stream_t frame_q [$];

    int unsigned lcg_state = 32'd87437;
    int          x1_re, x2_re, x1_im, x2_im;
    int          in_cnt;
    logic [PSS_LEN-1:0] win;
    int          win_fill;
    logic        peak_due;
    nid2_t       peak_idx;
    logic        frm_busy;
    int          frm_pos;
    int          armed, peaks, frames_out;
    int          checks, errors;
    int          cycle_cnt, cycle_limit;
    logic        mon_en;

    sync_top u_dut (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .in_i         (in_i),
        .dec_o        (dec_o),
        .peak_valid_o (peak_valid_o),
        .peak_nid2_o  (peak_nid2_o),
        .sym_o        (sym_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // y[k] = (x[2k] + 2x[2k-1] + x[2k-2]) >> 2, wrapped to the sample width
    function automatic logic [SAMPLE_DW-1:0] cic_ref(int x0, int x1, int x2);
        int s;
        s = x0 + 2 * x1 + x2;
        return SAMPLE_DW'(s >>> CIC_GAIN_SHIFT);
    endfunction

    task automatic read_stimulus();
        int    fd;
        int    n;
        int    cnt;
        string line;
        logic [15:0] re;
        logic [15:0] im;
        fd = $fopen("verification/sync_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            errors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() == 0 || line[0] == "#") continue;
            if (line[0] == "b") begin
                n = $sscanf(line, "b %d", cnt);
                assert (n == 1) else begin
                    $display("burst line in the stimulus file is malformed");
                    errors++;
                end
                nid_q.push_back(cnt);
            end else if (line[0] == "s") begin
                n = $sscanf(line, "s %h %h %d", re, im, cnt);
                assert (n == 3) else begin
                    $display("sample line in the stimulus file is malformed");
                    errors++;
                end
                repeat (cnt) stim_q.push_back({re, im});
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_sample(logic [31:0] word);
        int         re_s;
        int         im_s;
        int         idle;
        iq_sample_t exp_d;
        re_s = int'($signed(word[31:16]));
        im_s = int'($signed(word[15:0]));
        @(posedge clk_i);
        #1;
        in_i.valid   = 1'b1;
        in_i.data.re = word[31:16];
        in_i.data.im = word[15:0];
        if (in_cnt % CIC_RATE == 0) begin
            exp_d.re = cic_ref(re_s, x1_re, x2_re);
            exp_d.im = cic_ref(im_s, x1_im, x2_im);
            dec_q.push_back(exp_d);
        end
        x2_re = x1_re;
        x1_re = re_s;
        x2_im = x1_im;
        x1_im = im_s;
        in_cnt++;
        idle = int'((lcg_next() >> 16) % (MAX_IDLE + 1));
        repeat (idle) begin
            @(posedge clk_i);
            #1;
            in_i.valid = 1'b0;
        end
    endtask

    // software framer, fed with the model's decimated samples
    task automatic frame_model(iq_sample_t d, logic match);
        int p;
        int off;
        framed_stream_t f;
        if (frm_busy) begin
            frm_pos++;
            p   = frm_pos - 1;
            off = p % (CP_LEN + SYM_LEN);
            if (off >= CP_LEN) begin
                f       = '0;
                f.data  = d;
                f.valid = 1'b1;
                f.first = (off == CP_LEN);
                f.last  = (off == CP_LEN + SYM_LEN - 1);
                f.index = sym_idx_t'(p / (CP_LEN + SYM_LEN));
                frame_q.push_back(f);
            end
            if (frm_pos == BURST_SAMPLES) frm_busy = 1'b0;
        end else if (match) begin
            frm_busy = 1'b1;
            frm_pos  = 0;
            armed++;
        end
    endtask

    task automatic check_outputs();
        iq_sample_t     d;
        framed_stream_t f;
        logic           match;
        int             exp_nid;
        checks++;
        assert (peak_valid_o === peak_due) else begin
            $display("FAILED peak_valid_o: got %h expected %h", peak_valid_o, peak_due);
            errors++;
        end
        if (peak_due && peak_valid_o === 1'b1) begin
            exp_nid = (nid_q.size() > 0) ? nid_q.pop_front() : -1;
            checks++;
            assert (peak_nid2_o === peak_idx) else begin
                $display("FAILED peak_nid2_o: got %h expected %h", peak_nid2_o, peak_idx);
                errors++;
            end
            checks++;
            assert (int'(peak_nid2_o) == exp_nid) else begin
                $display("FAILED peak_nid2_o: got %h expected %h from the stimulus file",
                         peak_nid2_o, exp_nid);
                errors++;
            end
        end
        peak_due = 1'b0;
        if (dec_o.valid === 1'b1) begin
            checks++;
            assert (dec_q.size() > 0) else begin
                $display("decimated sample appeared with none expected");
                errors++;
            end
            if (dec_q.size() > 0) begin
                d = dec_q.pop_front();
                checks++;
                assert (dec_o.data === d) else begin
                    $display("FAILED dec_o.data: got %h expected %h", dec_o.data, d);
                    errors++;
                end
                win      = {win[PSS_LEN-2:0], ~d.re[SAMPLE_DW-1]};
                win_fill = (win_fill < PSS_LEN) ? win_fill + 1 : win_fill;
                match    = (win_fill == PSS_LEN) &&
                           (win == PSS_SEQ_0 || win == PSS_SEQ_1 || win == PSS_SEQ_2);
                if (match) begin
                    peak_due = 1'b1;
                    peak_idx = (win == PSS_SEQ_0) ? 2'd0 : (win == PSS_SEQ_1) ? 2'd1 : 2'd2;
                    peaks++;
                end
                frame_model(d, match);
            end
        end
        if (sym_o.valid === 1'b1) begin
            frames_out++;
            checks++;
            assert (frame_q.size() > 0) else begin
                $display("framed sample appeared outside a burst");
                errors++;
            end
            if (frame_q.size() > 0) begin
                f = frame_q.pop_front();
                checks++;
                assert (sym_o === f) else begin
                    $display("FAILED sym_o: got %h expected %h", sym_o, f);
                    errors++;
                end
            end
        end else begin
            checks++;
            assert (sym_o.valid === 1'b0 && sym_o.first === 1'b0 && sym_o.last === 1'b0)
            else begin
                $display("FAILED sym_o flags: got %h expected 0",
                         {sym_o.valid, sym_o.first, sym_o.last});
                errors++;
            end
        end
    endtask

    always @(negedge clk_i) begin
        if (mon_en) check_outputs();
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("run stopped after %0d cycles without finishing", cycle_cnt);
            $display("checks: %0d, errors: %0d", checks, errors + 1);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        in_i        = '0;
        reset_ni    = 1'b0;
        mon_en      = 1'b0;
        peak_due    = 1'b0;
        peak_idx    = '0;
        win         = '0;
        frm_busy    = 1'b0;
        cycle_limit = 100000;
        read_stimulus();
        cycle_limit = stim_q.size() * CIC_RATE * (MAX_IDLE + 1) + 200;
        @(posedge clk_i);
        #1;
        mon_en = 1'b1;  // outputs are cleared from the first reset edge on
        @(posedge clk_i);
        #1;
        reset_ni = 1'b1;
        repeat (3) @(posedge clk_i);
        foreach (stim_q[i]) drive_sample(stim_q[i]);
        @(posedge clk_i);
        #1;
        in_i.valid = 1'b0;
        while (dec_q.size() > 0 || frame_q.size() > 0 || frm_busy || peak_due) begin
            @(posedge clk_i);
        end
        repeat (4) @(posedge clk_i);
        checks++;
        assert (nid_q.size() == 0 && frames_out == armed * SYMS_PER_BURST * SYM_LEN) else begin
            $display("burst count wrong, %0d peaks and %0d framed samples", peaks, frames_out);
            errors++;
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verification/sync_input.txt
# b <n_id_2>: expected n_id_2 of the next PSS
# s <re hex> <im hex> <count>: one input sample, repeated count times
s 0000 0000 1
s 0000 0000 40
b 1
s fc18 0123 4
s 03e8 fedc 6
s fc18 0456 2
s 03e8 fba9 2
s fc18 0789 4
s 03e8 f876 4
s fc18 0abc 2
s 03e8 f543 2
s fc18 0def 4
s 03e8 f210 2
b 2
s 03e8 0111 2
s fc18 feee 6
s 03e8 0222 4
s fc18 fddd 2
s 03e8 0333 2
s fc18 fccc 4
s 03e8 0444 2
s fc18 fbbb 2
s 03e8 0555 6
s fc18 faaa 2
s 0000 0000 60
b 0
s 03e8 1234 6
s fc18 edcb 4
s 03e8 2345 2
s fc18 dcba 4
s 03e8 3456 2
s fc18 cba9 2
s 03e8 4567 4
s fc18 ba98 6
s 03e8 5678 2
s 0000 0000 64

//--- compile.f
source/sync_pkg.sv
source/cic_decimator.sv
source/pss_correlator.sv
source/sample_delay.sv
source/symbol_framer.sv
source/sync_top.sv
verification/sync_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run from the project root
verilator --binary --timing --top-module sync_tb -f compile.f -o sync_sim \
    && ./obj_dir/sync_sim | tee /dev/stderr | grep -q "All checks passed" \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
